//--- router.f
hdl/router_pkg.sv
hdl/flit_fifo.sv
hdl/route_decode.sv
hdl/switch_execute.sv
hdl/router.sv
test/router_sva.sv
test/router_tb.sv

//--- Bender.yml
package:
  name: router

sources:
  - hdl/router_pkg.sv
  - hdl/flit_fifo.sv
  - hdl/route_decode.sv
  - hdl/switch_execute.sv
  - hdl/router.sv
  - target: test
    files:
      - test/router_sva.sv
      - test/router_tb.sv

//--- test/router_tb.sv
`timescale 1ns/1ps

module router_tb;

    localparam logic [1:0] router_x = 2'd1;
    localparam logic [1:0] router_y = 2'd1;
    localparam int timeout_cycles = 200;
    localparam int bp_flits = 10;

    logic clk_if;
    logic reset;
    logic [router_pkg::num_ports-1:0] in_valid;
    router_pkg::flit_t in_flit [router_pkg::num_ports];
    logic [router_pkg::num_ports-1:0] in_ready;
    logic [router_pkg::num_ports-1:0] out_valid;
    router_pkg::flit_t out_flit [router_pkg::num_ports];
    logic [router_pkg::num_ports-1:0] out_ready;

    integer seed;
    int pass_count;
    int fail_count;

    // Flits seen leaving the router, in arrival order
    router_pkg::flit_t rx_flit_q [$];
    router_pkg::port_e rx_port_q [$];

    router #(
        .local_x (router_x),
        .local_y (router_y)
    ) dut0 (
        .clk_if    (clk_if),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_flit   (in_flit),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_flit  (out_flit),
        .out_ready (out_ready)
    );

    always #10 clk_if = ~clk_if;

    // A flit leaves on a rising edge with valid and ready both high
    always @(posedge clk_if)
    begin
        for (int p = 0; p < router_pkg::num_ports; p++)
        begin
            if (!reset && out_valid[p] && out_ready[p])
            begin
                rx_flit_q.push_back(out_flit[p]);
                rx_port_q.push_back(router_pkg::port_e'(p));
            end
        end
    end

    // Rows are resolved before columns
    function automatic router_pkg::port_e expected_port(input router_pkg::flit_t f);
        if (f.dst_y != router_y)
        begin
            return (f.dst_y > router_y) ? router_pkg::port_south : router_pkg::port_north;
        end
        if (f.dst_x == router_x)
        begin
            return router_pkg::port_central;
        end
        return (f.dst_x > router_x) ? router_pkg::port_east : router_pkg::port_west;
    endfunction

    function automatic router_pkg::flit_t make_flit(input logic [1:0] x, input logic [1:0] y);
        router_pkg::flit_t f;
        f.dst_x = x;
        f.dst_y = y;
        f.payload = router_pkg::payload_width'($random(seed));
        return f;
    endfunction

    task automatic compare_flit(input string name, input router_pkg::flit_t got,
                                input router_pkg::flit_t exp);
        if (got === exp)
        begin
            pass_count++;
        end
        else
        begin
            fail_count++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_port(input string name, input router_pkg::port_e got,
                                input router_pkg::port_e exp);
        if (got === exp)
        begin
            pass_count++;
        end
        else
        begin
            fail_count++;
            $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got === exp)
        begin
            pass_count++;
        end
        else
        begin
            fail_count++;
            $display("[ERROR] %0t ns: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic report_timeout(input string what);
        fail_count++;
        $display("Gave up after %0d cycles waiting for %s", timeout_cycles, what);
    endtask

    task automatic report_test_done(input string name, input int start_fails);
        $display("%s: finished with %0d error(s)", name, fail_count - start_fails);
    endtask

    // Offer one flit and hold it until the input queue takes it
    task automatic push_flit(input router_pkg::port_e p, input router_pkg::flit_t f);
        int waited;
        waited = 0;
        @(negedge clk_if);
        in_valid[p] = 1'b1;
        in_flit[p] = f;
        while (!in_ready[p] && waited < timeout_cycles)
        begin
            @(negedge clk_if);
            waited++;
        end
        if (!in_ready[p])
        begin
            report_timeout($sformatf("in_ready on input %0d", p));
        end
        @(negedge clk_if);
        in_valid[p] = 1'b0;
    endtask

    task automatic wait_rx(input int n, input string what);
        int waited;
        waited = 0;
        while (rx_flit_q.size() < n && waited < timeout_cycles)
        begin
            @(negedge clk_if);
            waited++;
        end
        if (rx_flit_q.size() < n)
        begin
            report_timeout(what);
        end
    endtask

    task automatic expect_next(input router_pkg::flit_t exp);
        router_pkg::flit_t got_flit;
        router_pkg::port_e got_port;
        if (rx_flit_q.size() == 0)
        begin
            fail_count++;
            $display("No flit arrived where payload %h was expected", exp.payload);
        end
        else
        begin
            got_flit = rx_flit_q.pop_front();
            got_port = rx_port_q.pop_front();
            compare_port("out port", got_port, expected_port(exp));
            compare_flit("out_flit", got_flit, exp);
        end
    endtask

    // Idle a while and make sure nothing else shows up
    task automatic check_no_extra();
        repeat (20) @(negedge clk_if);
        if (rx_flit_q.size() != 0)
        begin
            fail_count++;
            $display("%0d unexpected extra flit(s) left the router", rx_flit_q.size());
            rx_flit_q.delete();
            rx_port_q.delete();
        end
    endtask

    task automatic route_one(input logic [1:0] x, input logic [1:0] y,
                             input router_pkg::port_e src);
        router_pkg::flit_t f;
        f = make_flit(x, y);
        push_flit(src, f);
        wait_rx(1, "a routed flit");
        expect_next(f);
    endtask

    task automatic reset_state_test();
        int start;
        start = fail_count;
        @(negedge clk_if);
        for (int p = 0; p < router_pkg::num_ports; p++)
        begin
            compare_bit($sformatf("out_valid[%0d]", p), out_valid[p], 1'b0);
            compare_bit($sformatf("in_ready[%0d]", p), in_ready[p], 1'b1);
        end
        report_test_done("reset", start);
    endtask

    task automatic routing_test();
        int start;
        start = fail_count;
        route_one(2'd1, 2'd1, router_pkg::port_central);
        route_one(2'd1, 2'd0, router_pkg::port_north);
        route_one(2'd1, 2'd3, router_pkg::port_south);
        route_one(2'd3, 2'd1, router_pkg::port_east);
        route_one(2'd0, 2'd1, router_pkg::port_west);
        route_one(2'd3, 2'd3, router_pkg::port_central);
        route_one(2'd0, 2'd0, router_pkg::port_east);
        check_no_extra();
        report_test_done("routing", start);
    endtask

    task automatic ordering_test();
        router_pkg::flit_t f [4];
        int start;
        start = fail_count;
        for (int i = 0; i < 4; i++)
        begin
            f[i] = make_flit(2'd1, 2'd3);
            push_flit(router_pkg::port_north, f[i]);
        end
        wait_rx(4, "four ordered flits");
        for (int i = 0; i < 4; i++)
        begin
            expect_next(f[i]);
        end
        check_no_extra();
        report_test_done("order", start);
    endtask

    task automatic backpressure_test();
        router_pkg::flit_t f [bp_flits];
        int start;
        int waited;
        start = fail_count;
        waited = 0;
        for (int i = 0; i < bp_flits; i++)
        begin
            f[i] = make_flit(2'd3, 2'd1);
        end
        @(negedge clk_if);
        out_ready[router_pkg::port_east] = 1'b0;
        fork
            begin
                for (int i = 0; i < bp_flits; i++)
                begin
                    push_flit(router_pkg::port_west, f[i]);
                end
            end
            begin
                // Input, switch and output all fill before in_ready drops
                while (in_ready[router_pkg::port_west] && waited < timeout_cycles)
                begin
                    @(negedge clk_if);
                    waited++;
                end
                if (in_ready[router_pkg::port_west])
                begin
                    report_timeout("in_ready to fall under back-pressure");
                end
                compare_bit("out_valid[3]", out_valid[router_pkg::port_east], 1'b1);
                out_ready[router_pkg::port_east] = 1'b1;
            end
        join
        wait_rx(bp_flits, "the back-pressured flits");
        for (int i = 0; i < bp_flits; i++)
        begin
            expect_next(f[i]);
        end
        check_no_extra();
        report_test_done("back-pressure", start);
    endtask

    task automatic fairness_test();
        router_pkg::flit_t f [router_pkg::num_ports];
        bit seen [router_pkg::num_ports];
        router_pkg::flit_t got_flit;
        router_pkg::port_e got_port;
        int hit;
        int start;
        start = fail_count;
        f[0] = make_flit(2'd1, 2'd1);
        f[1] = make_flit(2'd1, 2'd0);
        f[2] = make_flit(2'd1, 2'd2);
        f[3] = make_flit(2'd2, 2'd1);
        f[4] = make_flit(2'd0, 2'd1);
        // Low payload bits tag the source input
        for (int i = 0; i < router_pkg::num_ports; i++)
        begin
            f[i].payload[2:0] = 3'(i);
            seen[i] = 1'b0;
        end
        fork
            push_flit(router_pkg::port_central, f[0]);
            push_flit(router_pkg::port_north, f[1]);
            push_flit(router_pkg::port_south, f[2]);
            push_flit(router_pkg::port_east, f[3]);
            push_flit(router_pkg::port_west, f[4]);
        join
        wait_rx(router_pkg::num_ports, "one flit from every input");
        while (rx_flit_q.size() > 0)
        begin
            got_flit = rx_flit_q.pop_front();
            got_port = rx_port_q.pop_front();
            hit = int'(got_flit.payload[2:0]);
            if (hit >= router_pkg::num_ports || seen[hit])
            begin
                fail_count++;
                $display("Flit with payload %h was duplicated or never sent", got_flit.payload);
            end
            else
            begin
                seen[hit] = 1'b1;
                compare_port("out port", got_port, expected_port(f[hit]));
                compare_flit("out_flit", got_flit, f[hit]);
            end
        end
        for (int i = 0; i < router_pkg::num_ports; i++)
        begin
            if (!seen[i])
            begin
                fail_count++;
                $display("Flit offered on input %0d never arrived", i);
            end
        end
        check_no_extra();
        report_test_done("fairness", start);
    endtask

    initial
    begin
        seed = 56;
        pass_count = 0;
        fail_count = 0;
        clk_if = 1'b0;
        reset = 1'b1;
        in_valid = '0;
        out_ready = '1;
        for (int p = 0; p < router_pkg::num_ports; p++)
        begin
            in_flit[p] = '0;
        end
        repeat (8) @(negedge clk_if);
        reset = 1'b0;

        reset_state_test();
        routing_test();
        ordering_test();
        backpressure_test();
        fairness_test();

        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- test/router_sva.sv
`timescale 1ns/1ps

module router_sva (
    input logic                             clk_if,
    input logic                             reset,
    input logic [router_pkg::num_ports-1:0] in_pop,
    input logic [router_pkg::num_ports-1:0] out_push,
    input logic [router_pkg::num_ports-1:0] out_full
);

    // The switch writes at most one output queue per cycle
    push_onehot: assert property (@(posedge clk_if) disable iff (reset) $onehot0(out_push))
        else $error("more than one output queue pushed in one cycle");

    // A push into a full queue would be dropped silently
    push_not_full: assert property (@(posedge clk_if) disable iff (reset)
        (out_push & out_full) == '0)
        else $error("push into a full output queue");

    pop_onehot: assert property (@(posedge clk_if) disable iff (reset) $onehot0(in_pop))
        else $error("more than one input queue popped in one cycle");

endmodule

bind switch_execute router_sva u_sva (
    .clk_if   (clk_if),
    .reset    (reset),
    .in_pop   (in_pop),
    .out_push (out_push),
    .out_full (out_full)
);

//--- hdl/router.sv
`timescale 1ns/1ps

module router #(
    parameter logic [router_pkg::coord_width-1:0] local_x = '0,
    parameter logic [router_pkg::coord_width-1:0] local_y = '0
) (
    input  logic                               clk_if,
    input  logic                               reset,
    input  logic [router_pkg::num_ports-1:0]   in_valid,
    input  router_pkg::flit_t                  in_flit [router_pkg::num_ports],
    output logic [router_pkg::num_ports-1:0]   in_ready,
    output logic [router_pkg::num_ports-1:0]   out_valid,
    output router_pkg::flit_t                  out_flit [router_pkg::num_ports],
    input  logic [router_pkg::num_ports-1:0]   out_ready
);

    logic [router_pkg::num_ports-1:0] in_full;
    logic [router_pkg::num_ports-1:0] in_empty;
    logic [router_pkg::num_ports-1:0] in_pop;
    router_pkg::flit_t in_head [router_pkg::num_ports];
    logic [router_pkg::num_ports-1:0] out_full;
    logic [router_pkg::num_ports-1:0] out_empty;
    logic [router_pkg::num_ports-1:0] out_push;
    router_pkg::flit_t sw_flit;
    router_pkg::port_e route_port;

    for (genvar p = 0; p < router_pkg::num_ports; p++)
    begin : gen_port
        // Ingress handshake, ready while the input queue has room
        assign in_ready[p] = ~in_full[p];

        // Egress valid follows the queue state, not the pop strobe
        assign out_valid[p] = ~out_empty[p];

        flit_fifo u_in_q (
            .clk_if    (clk_if),
            .reset     (reset),
            .push      (in_valid[p] & ~in_full[p]),
            .push_flit (in_flit[p]),
            .full      (in_full[p]),
            .pop       (in_pop[p]),
            .head_flit (in_head[p]),
            .empty     (in_empty[p])
        );

        flit_fifo u_out_q (
            .clk_if    (clk_if),
            .reset     (reset),
            .push      (out_push[p]),
            .push_flit (sw_flit),
            .full      (out_full[p]),
            .pop       (out_ready[p] & ~out_empty[p]),
            .head_flit (out_flit[p]),
            .empty     (out_empty[p])
        );
    end

    // Decode stage
    route_decode #(
        .local_x (local_x),
        .local_y (local_y)
    ) u_decode (
        .flit     (sw_flit),
        .out_port (route_port)
    );

    // Execute stage
    switch_execute u_switch (
        .clk_if     (clk_if),
        .reset      (reset),
        .in_empty   (in_empty),
        .in_head    (in_head),
        .in_pop     (in_pop),
        .flit       (sw_flit),
        .route_port (route_port),
        .out_full   (out_full),
        .out_push   (out_push)
    );

endmodule

//--- hdl/switch_execute.sv
`timescale 1ns/1ps

module switch_execute (
    input  logic                               clk_if,
    input  logic                               reset,
    input  logic [router_pkg::num_ports-1:0]   in_empty,
    input  router_pkg::flit_t                  in_head [router_pkg::num_ports],
    output logic [router_pkg::num_ports-1:0]   in_pop,
    output router_pkg::flit_t                  flit,
    input  router_pkg::port_e                  route_port,
    input  logic [router_pkg::num_ports-1:0]   out_full,
    output logic [router_pkg::num_ports-1:0]   out_push
);

    router_pkg::switch_state_e state;
    // First port searched on the next poll
    router_pkg::port_e rr_ptr;
    router_pkg::port_e target;
    router_pkg::port_e grant_port;
    logic grant_valid;

    // Round-robin search over the input queues starting at rr_ptr
    always_comb
    begin : proc_grant
        int unsigned idx;
        grant_valid = 1'b0;
        grant_port = rr_ptr;
        idx = 0;
        for (int i = 0; i < router_pkg::num_ports; i++)
        begin
            idx = int'(rr_ptr) + i;
            if (idx >= router_pkg::num_ports)
            begin
                idx = idx - router_pkg::num_ports;
            end
            if (!grant_valid && !in_empty[idx])
            begin
                grant_valid = 1'b1;
                grant_port = router_pkg::port_e'(idx[router_pkg::port_width-1:0]);
            end
        end
    end

    // Pop the granted queue in the poll cycle, its head is latched on the same edge
    always_comb
    begin
        in_pop = '0;
        if (state == router_pkg::st_poll && grant_valid)
        begin
            in_pop[grant_port] = 1'b1;
        end
    end

    // Only the target queue is written, and only while it has room
    always_comb
    begin
        out_push = '0;
        if (state == router_pkg::st_send && !out_full[target])
        begin
            out_push[target] = 1'b1;
        end
    end

    always_ff @(posedge clk_if)
    begin
        if (state == router_pkg::st_poll && grant_valid)
        begin
            flit <= in_head[grant_port];
        end
    end

    always_ff @(posedge clk_if)
    begin
        if (reset)
        begin
            state <= router_pkg::st_poll;
            rr_ptr <= router_pkg::port_central;
            target <= router_pkg::port_central;
        end
        else
        begin
            case (state)
                router_pkg::st_poll:
                begin
                    if (grant_valid)
                    begin
                        // Next search begins after the port just served
                        if (grant_port == router_pkg::port_e'(router_pkg::num_ports - 1))
                        begin
                            rr_ptr <= router_pkg::port_central;
                        end
                        else
                        begin
                            rr_ptr <= router_pkg::port_e'(grant_port + 1'b1);
                        end
                        state <= router_pkg::st_route;
                    end
                end
                router_pkg::st_route:
                begin
                    target <= route_port;
                    state <= router_pkg::st_send;
                end
                router_pkg::st_send:
                begin
                    // Stall here while the output queue is full
                    if (!out_full[target])
                    begin
                        state <= router_pkg::st_poll;
                    end
                end
                default:
                begin
                    state <= router_pkg::st_poll;
                end
            endcase
        end
    end

endmodule

//--- hdl/route_decode.sv
`timescale 1ns/1ps

module route_decode #(
    parameter logic [router_pkg::coord_width-1:0] local_x = '0,
    parameter logic [router_pkg::coord_width-1:0] local_y = '0
) (
    input  router_pkg::flit_t flit,
    output router_pkg::port_e out_port
);

    // Dimension-ordered routing, Y first then X
    always_comb
    begin
        if (flit.dst_y > local_y)
        begin
            // Larger row index lies to the south
            out_port = router_pkg::port_south;
        end
        else if (flit.dst_y < local_y)
        begin
            out_port = router_pkg::port_north;
        end
        else if (flit.dst_x > local_x)
        begin
            out_port = router_pkg::port_east;
        end
        else if (flit.dst_x < local_x)
        begin
            out_port = router_pkg::port_west;
        end
        else
        begin
            // Arrived, deliver locally
            out_port = router_pkg::port_central;
        end
    end

endmodule

//--- hdl/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo (
    input  logic              clk_if,
    input  logic              reset,
    input  logic              push,
    input  router_pkg::flit_t push_flit,
    output logic              full,
    input  logic              pop,
    output router_pkg::flit_t head_flit,
    output logic              empty
);

    router_pkg::flit_t mem [router_pkg::fifo_depth];
    logic [router_pkg::fifo_ptr_width-1:0] wr_ptr;
    logic [router_pkg::fifo_ptr_width-1:0] rd_ptr;
    logic [router_pkg::fifo_count_width-1:0] count;
    logic do_push;
    logic do_pop;

    // Pointer increment with wrap at the last entry
    function automatic logic [router_pkg::fifo_ptr_width-1:0] next_ptr(
        input logic [router_pkg::fifo_ptr_width-1:0] ptr
    );
        if (ptr == router_pkg::fifo_ptr_width'(router_pkg::fifo_depth - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == router_pkg::fifo_count_width'(router_pkg::fifo_depth));
    assign empty = (count == '0);

    // Requests that hit a full or empty queue are dropped here
    assign do_push = push & ~full;
    assign do_pop = pop & ~empty;

    // Show-ahead read port
    assign head_flit = mem[rd_ptr];

    always_ff @(posedge clk_if)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_flit;
        end
    end

    always_ff @(posedge clk_if)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Push and pop together leave the occupancy as it is
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/router_pkg.sv
package router_pkg;

    // Router geometry
    localparam int num_ports = 5;
    localparam int port_width = $clog2(num_ports);
    localparam int coord_width = 2;
    localparam int payload_width = 16;

    // Queue sizing, shared by the input and output queues
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    localparam int fifo_count_width = $clog2(fifo_depth + 1);

    // Port indices, also used as output routing decisions
    typedef enum logic [port_width-1:0] {
        port_central = 0,
        port_north   = 1,
        port_south   = 2,
        port_east    = 3,
        port_west    = 4
    } port_e;

    // Switch controller states
    typedef enum logic [1:0] {
        st_poll,
        st_route,
        st_send
    } switch_state_e;

    // One flit: destination coordinates followed by payload
    typedef struct packed {
        logic [coord_width-1:0]   dst_x;
        logic [coord_width-1:0]   dst_y;
        logic [payload_width-1:0] payload;
    } flit_t;

endpackage
